//--- files.f
rtl/gat_pkg.sv
rtl/spmm_unit.sv
rtl/dmvm_unit.sv
rtl/sm_unit.sv
rtl/aggr_unit.sv
rtl/debug_monitor.sv
rtl/gat_layer.sv
testbench/gat_layer_asserts.sv
testbench/gat_layer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds gat_layer_tb with Verilator, runs it into sim.log and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module gat_layer_tb -Mdir obj_dir -f files.f \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vgat_layer_tb > sim.log 2>&1 || run_failed=1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
[ -z "$run_failed" ] || { echo "Simulation stopped early"; exit 1; }
echo "Simulation passed"

//--- testbench/gat_layer_tb.sv
`default_nettype none

module gat_layer_tb
  import gat_pkg::*;
;

  localparam int GROUP_SIZE = 12;
  localparam int ADDR_LIMIT = 3;
  localparam int CAP_A      = 10;
  localparam int CAP_B      = 20;
  localparam int WAIT_LIMIT = 2000;

  logic        clk;
  logic        rst_n;
  logic        in_vld;
  lane_vec_t   feat;
  lane_vec_t   coef;
  logic        in_rdy;
  logic        feat_rdy;
  logic        feat_we;
  feat_addr_t  feat_addr;
  feat_word_t  feat_din;
  logic [31:0] debug_cfg;
  logic [31:0] debug_status;
  logic [31:0] debug_count;
  logic [31:0] debug_capture;

  integer seed;
  int     errors;
  int     item_idx;
  int     group_cnt;
  int     group_acc;
  int     write_cnt;
  int     exp_q[$];   // Expected group sums in write order
  lane_t  cap_a_exp;
  lane_t  cap_b_exp;
  logic   limit_exp;
  logic   in_rdy_fell;
  logic   neg_seen;

  gat_layer #(
    .H_NUM_SPARSE_DATA (GROUP_SIZE),
    .FEAT_ADDR_LIMIT   (ADDR_LIMIT),
    .CAP_ADDR_A        (CAP_A),
    .CAP_ADDR_B        (CAP_B)
  ) dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_vld_i        (in_vld),
    .feat_i          (feat),
    .coef_i          (coef),
    .in_rdy_o        (in_rdy),
    .feat_rdy_i      (feat_rdy),
    .feat_we_o       (feat_we),
    .feat_addr_o     (feat_addr),
    .feat_din_o      (feat_din),
    .debug_cfg_o     (debug_cfg),
    .debug_status_o  (debug_status),
    .debug_count_o   (debug_count),
    .debug_capture_o (debug_capture)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic lane_t lane_prod(lane_t f, lane_t c);
    logic [23:0] full;
    full = f * c;
    return full[11:0];
  endfunction

  // Lane sum wraps to 16 bits and a negative value is floored to a quarter
  function automatic int leaky_score(int lane_sum);
    int w;
    w = lane_sum % 65536;
    if (w >= 32768) begin
      w = w - 65536;
    end
    if (w < 0) begin
      return (w - 3) / 4;
    end
    return w;
  endfunction

  function automatic logic rand_ready();
    int r;
    r = $random(seed);
    return (r[1:0] == 2'b00);  // Ready about one cycle in four
  endfunction

  task automatic report_value(input string what, input int got, input int exp);
    errors++;
    $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
    $display("Errors: %0d", errors);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic fill_features();
    for (int l = 0; l < NUM_LANES; l++) begin
      feat[l] = lane_t'($random(seed));
    end
  endtask

  task automatic model_accept(input lane_vec_t f);
    int    lane_sum;
    int    score;
    lane_t p;
    lane_sum = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      p = lane_prod(f[l], coef[l]);
      lane_sum += int'(p);
      if (l == 2 && item_idx == CAP_A) cap_a_exp = p;
      if (l == 2 && item_idx == CAP_B) cap_b_exp = p;
    end
    score = leaky_score(lane_sum);
    if (score < 0) neg_seen = 1'b1;
    group_acc += score;
    group_cnt++;
    if (group_cnt == GROUP_SIZE) begin
      exp_q.push_back(group_acc);
      group_acc = 0;
      group_cnt = 0;
    end
    item_idx++;
  endtask

  // Handshakes are stable at the falling edge and transfer on the next rising one
  always @(negedge clk) begin : observe
    int exp_sum;
    if (rst_n) begin
      if (in_vld && in_rdy) model_accept(feat);
      if (!in_rdy) in_rdy_fell = 1'b1;
      assert (debug_status[9] == limit_exp)
        else report_value("debug_status bit 9", debug_status[9], limit_exp);
      if (feat_we && feat_rdy) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("Feature write at address %0d was not expected", feat_addr);
        end
        if (exp_q.size() > 0) begin
          exp_sum = exp_q.pop_front();
          assert (feat_din == exp_sum) else report_value("feat_din", feat_din, exp_sum);
        end
        assert (int'(feat_addr) == write_cnt)
          else report_value("feat_addr", feat_addr, write_cnt);
        if (write_cnt >= ADDR_LIMIT) limit_exp = 1'b1;
        write_cnt++;
      end
    end
  end

  task automatic reset_dut();
    rst_n       = 1'b0;
    in_vld      = 1'b0;
    feat_rdy    = 1'b0;
    item_idx    = 0;
    group_cnt   = 0;
    group_acc   = 0;
    write_cnt   = 0;
    cap_a_exp   = '0;
    cap_b_exp   = '0;
    limit_exp   = 1'b0;
    in_rdy_fell = 1'b0;
    neg_seen    = 1'b0;
    exp_q.delete();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic send_beats(input int count, input logic random_rdy);
    int   sent;
    int   waited;
    logic taken;
    sent   = 0;
    waited = 0;
    fill_features();
    in_vld = 1'b1;
    while (sent < count) begin
      if (random_rdy) feat_rdy = rand_ready();
      @(negedge clk);
      taken = in_rdy;
      @(posedge clk);
      #1;
      if (taken) begin
        sent++;
        waited = 0;
        fill_features();
      end else begin
        waited++;
        if (waited >= WAIT_LIMIT) abort_on_timeout("the input port to accept a beat");
      end
    end
    in_vld = 1'b0;
  endtask

  task automatic wait_writes(input int count, input logic random_rdy);
    int waited;
    waited = 0;
    while (write_cnt < count) begin
      if (waited >= WAIT_LIMIT) abort_on_timeout("feature writes");
      if (random_rdy) feat_rdy = rand_ready();
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  task automatic check_reset_state();
    assert (debug_cfg == 32'(GROUP_SIZE)) else report_value("debug_cfg", debug_cfg, GROUP_SIZE);
    assert (debug_status == '0) else report_value("debug_status", debug_status, 0);
    assert (debug_count == '0) else report_value("debug_count", debug_count, 0);
    assert (debug_capture == '0) else report_value("debug_capture", debug_capture, 0);
    @(posedge clk);
    #1;
    assert (debug_status == 32'h54) else report_value("debug_status", debug_status, 32'h54);
  endtask

  task automatic run_single_group();
    feat_rdy = 1'b1;
    send_beats(GROUP_SIZE, 1'b0);
    wait_writes(1, 1'b0);
    assert (neg_seen) else begin
      errors++;
      $display("No negative lane sum occurred in the first group");
    end
  endtask

  task automatic check_captures();
    int waited;
    waited = 0;
    send_beats(GROUP_SIZE, 1'b0);
    while (debug_count != 32'd24) begin
      if (waited >= WAIT_LIMIT) abort_on_timeout("24 scored items");
      @(posedge clk);
      #1;
      waited++;
    end
    wait_writes(2, 1'b0);
    assert (debug_capture == {8'b0, cap_b_exp, cap_a_exp})
      else report_value("debug_capture", debug_capture, {8'b0, cap_b_exp, cap_a_exp});
  endtask

  task automatic run_backpressure();
    reset_dut();
    send_beats(5 * GROUP_SIZE, 1'b1);
    wait_writes(5, 1'b1);
    feat_rdy = 1'b1;
    assert (debug_count == 32'(5 * GROUP_SIZE))
      else report_value("debug_count", debug_count, 5 * GROUP_SIZE);
    assert (in_rdy_fell) else begin
      errors++;
      $display("Back-pressure never reached the input port");
    end
    assert (debug_status[8:0] == 9'h1ff)
      else report_value("debug_status flags", debug_status[8:0], 9'h1ff);
  endtask

  task automatic check_limit_flag();
    @(posedge clk);
    #1;
    assert (debug_status[9]) else report_value("debug_status bit 9", debug_status[9], 1);
  endtask

  initial begin
    seed     = 32'ha368_12dd;
    errors   = 0;
    rst_n    = 1'b0;
    in_vld   = 1'b0;
    feat     = '0;
    feat_rdy = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      coef[l] = lane_t'(l * 263 + 1031);
    end
    reset_dut();
    check_reset_state();
    run_single_group();
    check_captures();
    run_backpressure();
    check_limit_flag();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/gat_layer_asserts.sv
`default_nettype none

module gat_layer_asserts
  import gat_pkg::*;
(
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        in_vld_i,
  input wire logic        in_rdy_i,
  input wire lane_vec_t   feat_i,
  input wire logic        spmm_vld_i,
  input wire spmm_out_t   spmm_data_i,
  input wire logic        dmvm_rdy_i,
  input wire logic        dmvm_vld_i,
  input wire dmvm_out_t   dmvm_data_i,
  input wire logic        sm_rdy_i,
  input wire logic        sm_vld_i,
  input wire score_t      sm_score_i,
  input wire logic        aggr_rdy_i,
  input wire logic        feat_we_i,
  input wire logic        feat_rdy_i,
  input wire feat_addr_t  feat_addr_i,
  input wire feat_word_t  feat_din_i,
  input wire logic [31:0] debug_status_i
);

  // A stalled valid keeps itself and its payload until the transfer
  in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_vld_i && !in_rdy_i |=> in_vld_i && $stable(feat_i))
    else $error("Input beat changed while stalled");

  spmm_hold: assert property (@(posedge clk) disable iff (!rst_n)
    spmm_vld_i && !dmvm_rdy_i |=> spmm_vld_i && $stable(spmm_data_i))
    else $error("spmm output changed while stalled");

  dmvm_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dmvm_vld_i && !sm_rdy_i |=> dmvm_vld_i && $stable(dmvm_data_i))
    else $error("dmvm output changed while stalled");

  sm_hold: assert property (@(posedge clk) disable iff (!rst_n)
    sm_vld_i && !aggr_rdy_i |=> sm_vld_i && $stable(sm_score_i))
    else $error("sm score changed while stalled");

  write_hold: assert property (@(posedge clk) disable iff (!rst_n)
    feat_we_i && !feat_rdy_i |=> feat_we_i && $stable(feat_din_i) && $stable(feat_addr_i))
    else $error("Feature write changed while stalled");

  status_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    (debug_status_i & $past(debug_status_i)) == $past(debug_status_i))
    else $error("A debug status bit fell");

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !feat_we_i)
    else $error("Feature write enable high during reset");

endmodule

bind gat_layer gat_layer_asserts u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .in_vld_i       (in_vld_i),
  .in_rdy_i       (in_rdy_o),
  .feat_i         (feat_i),
  .spmm_vld_i     (spmm_vld),
  .spmm_data_i    (spmm_data),
  .dmvm_rdy_i     (dmvm_rdy),
  .dmvm_vld_i     (dmvm_vld),
  .dmvm_data_i    (dmvm_data),
  .sm_rdy_i       (sm_rdy),
  .sm_vld_i       (sm_vld),
  .sm_score_i     (sm_score),
  .aggr_rdy_i     (aggr_rdy),
  .feat_we_i      (feat_we_o),
  .feat_rdy_i     (feat_rdy_i),
  .feat_addr_i    (feat_addr_o),
  .feat_din_i     (feat_din_o),
  .debug_status_i (debug_status_o)
);

`default_nettype wire

//--- rtl/gat_layer.sv
`default_nettype none

module gat_layer
  import gat_pkg::*;
#(
  parameter int H_NUM_SPARSE_DATA = 12,
  parameter int FEAT_ADDR_LIMIT   = 3,
  parameter int CAP_ADDR_A        = 10,
  parameter int CAP_ADDR_B        = 20
) (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      in_vld_i,
  input  wire lane_vec_t feat_i,
  input  wire lane_vec_t coef_i,  // Static coefficients
  output logic           in_rdy_o,
  input  wire logic      feat_rdy_i,
  output logic           feat_we_o,
  output feat_addr_t     feat_addr_o,
  output feat_word_t     feat_din_o,
  output logic [31:0]    debug_cfg_o,
  output logic [31:0]    debug_status_o,
  output logic [31:0]    debug_count_o,
  output logic [31:0]    debug_capture_o
);

  logic          spmm_vld;
  spmm_out_t     spmm_data;
  logic          dmvm_rdy;
  logic          dmvm_vld;
  dmvm_out_t     dmvm_data;
  wh_addr_t      wh_addr;
  logic          sm_rdy;
  logic          sm_vld;
  score_t        sm_score;
  logic          aggr_rdy;
  stage_status_t status;

  spmm_unit u_spmm (
    .clk    (clk),
    .rst_n  (rst_n),
    .vld_i  (in_vld_i),
    .feat_i (feat_i),
    .coef_i (coef_i),
    .rdy_o  (in_rdy_o),
    .vld_o  (spmm_vld),
    .data_o (spmm_data),
    .rdy_i  (dmvm_rdy)
  );

  dmvm_unit u_dmvm (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld_i     (spmm_vld),
    .data_i    (spmm_data),
    .rdy_o     (dmvm_rdy),
    .vld_o     (dmvm_vld),
    .data_o    (dmvm_data),
    .rdy_i     (sm_rdy),
    .wh_addr_o (wh_addr)
  );

  sm_unit u_sm (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld_i   (dmvm_vld),
    .data_i  (dmvm_data),
    .rdy_o   (sm_rdy),
    .vld_o   (sm_vld),
    .score_o (sm_score),
    .rdy_i   (aggr_rdy)
  );

  aggr_unit #(
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA)
  ) u_aggr (
    .clk         (clk),
    .rst_n       (rst_n),
    .vld_i       (sm_vld),
    .score_i     (sm_score),
    .rdy_o       (aggr_rdy),
    .feat_rdy_i  (feat_rdy_i),
    .feat_we_o   (feat_we_o),
    .feat_addr_o (feat_addr_o),
    .feat_din_o  (feat_din_o)
  );

  // Each link is named after the stage that drives its valid
  assign status = '{
    spmm_vld: spmm_vld,
    spmm_rdy: dmvm_rdy,
    dmvm_vld: dmvm_vld,
    dmvm_rdy: sm_rdy,
    sm_vld:   sm_vld,
    sm_rdy:   aggr_rdy,
    aggr_vld: feat_we_o,
    aggr_rdy: feat_rdy_i
  };

  debug_monitor #(
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA),
    .FEAT_ADDR_LIMIT   (FEAT_ADDR_LIMIT),
    .CAP_ADDR_A        (CAP_ADDR_A),
    .CAP_ADDR_B        (CAP_ADDR_B)
  ) u_debug (
    .clk             (clk),
    .rst_n           (rst_n),
    .status_i        (status),
    .sppe_i          (spmm_data.sppe),
    .wh_addr_i       (wh_addr),
    .feat_we_i       (feat_we_o),
    .feat_addr_i     (feat_addr_o),
    .debug_cfg_o     (debug_cfg_o),
    .debug_status_o  (debug_status_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

endmodule

`default_nettype wire

//--- rtl/debug_monitor.sv
`default_nettype none

module debug_monitor
  import gat_pkg::*;
#(
  parameter int H_NUM_SPARSE_DATA = 12,
  parameter int FEAT_ADDR_LIMIT   = 3,
  parameter int CAP_ADDR_A        = 10,
  parameter int CAP_ADDR_B        = 20
) (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire stage_status_t status_i,
  input  wire lane_vec_t     sppe_i,
  input  wire wh_addr_t      wh_addr_i,
  input  wire logic          feat_we_i,
  input  wire feat_addr_t    feat_addr_i,
  output logic [31:0]        debug_cfg_o,
  output logic [31:0]        debug_status_o,
  output logic [31:0]        debug_count_o,
  output logic [31:0]        debug_capture_o
);

  stage_status_t seen_q;      // One sticky bit per handshake signal
  logic          we_seen_q;
  logic          addr_hit_q;
  logic [31:0]   sm_cnt_q;
  lane_t         cap_a_q;
  lane_t         cap_b_q;

  logic spmm_xfer;
  logic sm_xfer;
  logic feat_xfer;
  logic addr_hit;
  logic cap_a_hit;
  logic cap_b_hit;

  assign spmm_xfer = status_i.spmm_vld && status_i.spmm_rdy;
  assign sm_xfer   = status_i.sm_vld && status_i.sm_rdy;
  assign feat_xfer = feat_we_i && status_i.aggr_rdy;

  assign addr_hit  = feat_xfer && (feat_addr_i >= feat_addr_t'(FEAT_ADDR_LIMIT));
  assign cap_a_hit = spmm_xfer && (wh_addr_i == wh_addr_t'(CAP_ADDR_A));
  assign cap_b_hit = spmm_xfer && (wh_addr_i == wh_addr_t'(CAP_ADDR_B));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_q     <= '0;
      we_seen_q  <= 1'b0;
      addr_hit_q <= 1'b0;
    end else begin
      seen_q     <= seen_q | status_i;
      we_seen_q  <= we_seen_q | feat_we_i;
      addr_hit_q <= addr_hit_q | addr_hit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_cnt_q <= '0;
    end else if (sm_xfer) begin
      sm_cnt_q <= sm_cnt_q + 1'b1;
    end
  end

  // Lane 2 of the item that is about to take the capture address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else begin
      if (cap_a_hit) begin
        cap_a_q <= sppe_i[2];
      end
      if (cap_b_hit) begin
        cap_b_q <= sppe_i[2];
      end
    end
  end

  assign debug_cfg_o     = 32'(H_NUM_SPARSE_DATA);
  assign debug_status_o  = {22'b0, addr_hit_q, we_seen_q, seen_q};
  assign debug_count_o   = sm_cnt_q;
  assign debug_capture_o = {8'b0, cap_b_q, cap_a_q};

endmodule

`default_nettype wire

//--- rtl/aggr_unit.sv
`default_nettype none

module aggr_unit
  import gat_pkg::*;
#(
  parameter int H_NUM_SPARSE_DATA = 12
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   vld_i,
  input  wire score_t score_i,
  output logic        rdy_o,
  input  wire logic   feat_rdy_i,
  output logic        feat_we_o,
  output feat_addr_t  feat_addr_o,
  output feat_word_t  feat_din_o
);

  localparam int CNT_W = (H_NUM_SPARSE_DATA > 1) ? $clog2(H_NUM_SPARSE_DATA) : 1;

  logic [CNT_W-1:0] item_cnt;
  feat_word_t       acc;
  feat_word_t       group_sum;
  logic             take_in;
  logic             last_item;

  assign rdy_o     = !feat_we_o || feat_rdy_i;  // Stall while a finished write waits
  assign take_in   = vld_i && rdy_o;
  assign last_item = (item_cnt == CNT_W'(H_NUM_SPARSE_DATA - 1));
  assign group_sum = acc + feat_word_t'(score_i);  // Sign-extended score

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      item_cnt    <= '0;
      acc         <= '0;
      feat_we_o   <= 1'b0;
      feat_addr_o <= '0;
    end else begin
      if (feat_we_o && feat_rdy_i) begin
        feat_we_o   <= 1'b0;
        feat_addr_o <= feat_addr_o + 1'b1;
      end
      if (take_in) begin
        if (last_item) begin
          item_cnt  <= '0;
          acc       <= '0;
          feat_we_o <= 1'b1;  // Overrides the clear above
        end else begin
          item_cnt <= item_cnt + 1'b1;
          acc      <= group_sum;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_in && last_item) begin
      feat_din_o <= group_sum;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sm_unit.sv
`default_nettype none

module sm_unit
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      vld_i,
  input  wire dmvm_out_t data_i,
  output logic           rdy_o,
  output logic           vld_o,
  output score_t         score_o,
  input  wire logic      rdy_i
);

  score_t wh_s;
  score_t relu;
  logic   take_in;

  // Leaky ReLU with a slope of one quarter below zero
  assign wh_s = score_t'(data_i.wh);
  assign relu = (wh_s < 0) ? (wh_s >>> 2) : wh_s;

  assign rdy_o   = !vld_o || rdy_i;
  assign take_in = vld_i && rdy_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_o <= 1'b0;
    end else if (take_in) begin
      vld_o <= 1'b1;
    end else if (rdy_i) begin
      vld_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) begin
      score_o <= relu;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dmvm_unit.sv
`default_nettype none

module dmvm_unit
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      vld_i,
  input  wire spmm_out_t data_i,
  output logic           rdy_o,
  output logic           vld_o,
  output dmvm_out_t      data_o,
  input  wire logic      rdy_i,
  output wh_addr_t       wh_addr_o
);

  wh_t  lane_sum;
  logic take_in;

  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_sum = lane_sum + wh_t'(data_i.sppe[l]);  // Wraps at 16 bits
    end
  end

  assign rdy_o   = !vld_o || rdy_i;
  assign take_in = vld_i && rdy_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_o     <= 1'b0;
      wh_addr_o <= '0;
    end else begin
      if (take_in) begin
        vld_o     <= 1'b1;
        wh_addr_o <= wh_addr_o + 1'b1;  // Address of the next item
      end else if (rdy_i) begin
        vld_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) begin
      data_o.wh      <= lane_sum;
      data_o.wh_addr <= wh_addr_o;
    end
  end

endmodule

`default_nettype wire

//--- rtl/spmm_unit.sv
`default_nettype none

module spmm_unit
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      vld_i,
  input  wire lane_vec_t feat_i,
  input  wire lane_vec_t coef_i,
  output logic           rdy_o,
  output logic           vld_o,
  output spmm_out_t      data_o,
  input  wire logic      rdy_i
);

  lane_vec_t prod;
  logic      take_in;

  // Low 12 bits of each lane product
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      prod[l] = lane_t'(feat_i[l] * coef_i[l]);
    end
  end

  assign rdy_o   = !vld_o || rdy_i;  // Empty, or emptied this cycle
  assign take_in = vld_i && rdy_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_o <= 1'b0;
    end else if (take_in) begin
      vld_o <= 1'b1;
    end else if (rdy_i) begin
      vld_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) begin
      data_o.sppe <= prod;
    end
  end

endmodule

`default_nettype wire

//--- rtl/gat_pkg.sv
`default_nettype none

package gat_pkg;

  localparam int NUM_LANES = 16;

  typedef logic [11:0] lane_t;
  typedef lane_t [NUM_LANES-1:0] lane_vec_t;  // Features, coefficients and sppe products

  typedef logic [13:0] wh_addr_t;
  typedef logic [15:0] wh_t;                  // Wrapping sum of the lane products
  typedef logic signed [15:0] score_t;

  typedef logic [15:0] feat_addr_t;
  typedef logic signed [31:0] feat_word_t;

  // Handshakes of the four stage links, aggr_rdy ends up at bit 0
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_status_t;

  typedef struct packed {
    lane_vec_t sppe;
  } spmm_out_t;

  typedef struct packed {
    wh_t      wh;
    wh_addr_t wh_addr;
  } dmvm_out_t;

endpackage

`default_nettype wire
